/* hdl/uart_cmd_pkg.sv */
// =========================================================================
// UART command endpoint definitions
// Frame markers, command and reply codes, and the frame descriptor
// =========================================================================
`default_nettype none

package uart_cmd_pkg;

    // Start of frame pair
    localparam logic [7:0] SOF1_BYTE = 8'hAA;
    localparam logic [7:0] SOF2_BYTE = 8'h55;

    // =====================================================================
    // Command codes
    // =====================================================================
    localparam logic [7:0] CMD_SUM   = 8'h01;
    localparam logic [7:0] CMD_XOR   = 8'h02;
    localparam logic [7:0] CMD_COUNT = 8'h03;

    // =====================================================================
    // Reply codes
    // =====================================================================
    localparam logic [7:0] REPLY_UNKNOWN   = 8'hEE;
    // Bad checksum or length above the payload memory
    localparam logic [7:0] REPLY_FRAME_ERR = 8'hFF;

    // Header fields of one frame, parser to executor
    typedef struct packed {
        logic [7:0]  cmd;
        logic [15:0] len;
    } frame_info_t;

endpackage

`default_nettype wire

/* hdl/uart_rx.sv */
// =========================================================================
// UART receiver, 8N1
// Oversampled receive path with a two-flop synchronizer, mid-bit sampling
// and one strobe per byte that ends in a valid stop bit
// =========================================================================
`timescale 1ns/10ps
`default_nettype none

module uart_rx #(
    parameter int CLKS_PER_BIT = 8
) (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        rx,
    output logic [7:0] rx_data,
    output logic       rx_valid
);

    localparam int CW = $clog2(CLKS_PER_BIT + 1);

    typedef enum logic [1:0] {R_IDLE, R_START, R_DATA, R_STOP} state_t;

    state_t        state;
    logic          rx_meta;
    logic          rx_sync;
    logic [CW-1:0] clk_cnt;
    logic [2:0]    bit_idx;
    logic [7:0]    shift;
    logic          bit_tick;

    assign bit_tick = (clk_cnt == CW'(CLKS_PER_BIT - 1));

    // Line idles high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= R_IDLE;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                R_IDLE: begin
                    if (!rx_sync) begin
                        state   <= R_START;
                        clk_cnt <= '0;
                    end
                end
                R_START: begin
                    // Recheck at mid start bit, a glitch goes back to idle
                    if (clk_cnt == CW'(CLKS_PER_BIT / 2 - 1)) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? R_IDLE : R_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                R_DATA: begin
                    if (bit_tick) begin
                        clk_cnt <= '0;
                        if (bit_idx == 3'd7) begin
                            state <= R_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: begin
                    // Low stop bit means framing failure, no strobe
                    if (bit_tick) begin
                        clk_cnt  <= '0;
                        rx_valid <= rx_sync;
                        state    <= R_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // LSB first
    always_ff @(posedge clk) begin
        if (state == R_DATA && bit_tick) begin
            shift <= {rx_sync, shift[7:1]};
        end
        if (state == R_STOP && bit_tick) begin
            rx_data <= shift;
        end
    end

endmodule

`default_nettype wire

/* hdl/frame_parser.sv */
// =========================================================================
// Frame parser
// Finds the SOF pair, takes command, length, payload and checksum, stores
// the payload and flags the end of each frame as done or error
// =========================================================================
`timescale 1ns/10ps
`default_nettype none

module frame_parser #(
    parameter int MAX_PAYLOAD_LEN = 16
) (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire  [7:0]                         rx_data,
    input  wire                                rx_valid,
    input  wire  [$clog2(MAX_PAYLOAD_LEN)-1:0] payload_addr,
    output logic [7:0]                         payload_data,
    output uart_cmd_pkg::frame_info_t          frame_info,
    output logic                               parse_done,
    output logic                               parse_error
);

    import uart_cmd_pkg::*;

    localparam int AW = $clog2(MAX_PAYLOAD_LEN);

    typedef enum logic [2:0] {
        S_IDLE,
        S_SOF2,
        S_CMD,
        S_LEN_H,
        S_LEN_L,
        S_PAYLOAD,
        S_CHECKSUM
    } state_t;

    state_t        state;
    logic [7:0]    checksum;
    logic [AW-1:0] wr_addr;
    logic [15:0]   len_next;
    logic [7:0]    mem [MAX_PAYLOAD_LEN];

    // Full length as soon as the low byte arrives
    assign len_next = {frame_info.len[15:8], rx_data};

    // =====================================================================
    // Frame state machine, one step per received byte
    // =====================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= S_IDLE;
            checksum    <= '0;
            wr_addr     <= '0;
            frame_info  <= '0;
            parse_done  <= 1'b0;
            parse_error <= 1'b0;
        end else begin
            parse_done  <= 1'b0;
            parse_error <= 1'b0;
            if (rx_valid) begin
                case (state)
                    S_IDLE: begin
                        if (rx_data == SOF1_BYTE) begin
                            state <= S_SOF2;
                        end
                    end
                    S_SOF2: begin
                        checksum <= '0;
                        state    <= (rx_data == SOF2_BYTE) ? S_CMD : S_IDLE;
                    end
                    S_CMD: begin
                        frame_info.cmd <= rx_data;
                        checksum       <= checksum + rx_data;
                        state          <= S_LEN_H;
                    end
                    S_LEN_H: begin
                        frame_info.len[15:8] <= rx_data;
                        checksum             <= checksum + rx_data;
                        state                <= S_LEN_L;
                    end
                    S_LEN_L: begin
                        frame_info.len[7:0] <= rx_data;
                        checksum            <= checksum + rx_data;
                        wr_addr             <= '0;
                        if (len_next > 16'(MAX_PAYLOAD_LEN)) begin
                            // Would overrun the memory, reject now
                            parse_error <= 1'b1;
                            state       <= S_IDLE;
                        end else if (len_next == 16'd0) begin
                            state <= S_CHECKSUM;
                        end else begin
                            state <= S_PAYLOAD;
                        end
                    end
                    S_PAYLOAD: begin
                        checksum <= checksum + rx_data;
                        if (wr_addr == AW'(frame_info.len - 16'd1)) begin
                            state <= S_CHECKSUM;
                        end else begin
                            wr_addr <= wr_addr + 1'b1;
                        end
                    end
                    S_CHECKSUM: begin
                        parse_done  <= (rx_data == checksum);
                        parse_error <= (rx_data != checksum);
                        state       <= S_IDLE;
                    end
                    default: begin
                        state <= S_IDLE;
                    end
                endcase
            end
        end
    end

    // =====================================================================
    // Payload memory with registered read port
    // =====================================================================
    always_ff @(posedge clk) begin
        if (rx_valid && state == S_PAYLOAD) begin
            mem[wr_addr] <= rx_data;
        end
        payload_data <= mem[payload_addr];
    end

endmodule

`default_nettype wire

/* hdl/cmd_executor.sv */
// =========================================================================
// Command executor
// Walks the stored payload after a good frame and builds the one-byte
// reply, then hands it to the transmitter once the line is free
// =========================================================================
`timescale 1ns/10ps
`default_nettype none

module cmd_executor #(
    parameter int MAX_PAYLOAD_LEN = 16
) (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire uart_cmd_pkg::frame_info_t     frame_info,
    input  wire                                parse_done,
    input  wire                                parse_error,
    input  wire  [7:0]                         payload_data,
    input  wire                                tx_busy,
    output logic [$clog2(MAX_PAYLOAD_LEN)-1:0] payload_addr,
    output logic [7:0]                         tx_data,
    output logic                               tx_start
);

    import uart_cmd_pkg::*;

    localparam int AW = $clog2(MAX_PAYLOAD_LEN);

    typedef enum logic [1:0] {E_IDLE, E_WALK, E_HOLD} state_t;

    state_t        state;
    frame_info_t   info;
    logic [AW-1:0] last_addr;
    logic          addr_vld;
    logic          data_vld;
    logic          data_last;
    logic [7:0]    acc;
    logic [7:0]    next_acc;
    logic          start_walk;
    logic          reply_ready;
    logic [7:0]    reply_val;

    assign last_addr = AW'(info.len - 16'd1);
    assign next_acc  = (info.cmd == CMD_XOR) ? (acc ^ payload_data) : (acc + payload_data);

    // Reply decision, either immediate or at the end of the walk
    always_comb begin
        start_walk  = 1'b0;
        reply_ready = 1'b0;
        reply_val   = REPLY_UNKNOWN;
        if (state == E_IDLE && parse_error) begin
            reply_ready = 1'b1;
            reply_val   = REPLY_FRAME_ERR;
        end else if (state == E_IDLE && parse_done) begin
            reply_ready = 1'b1;
            case (frame_info.cmd)
                CMD_SUM, CMD_XOR: begin
                    // Empty payload folds to zero
                    reply_val = 8'h00;
                    if (frame_info.len != 16'd0) begin
                        reply_ready = 1'b0;
                        start_walk  = 1'b1;
                    end
                end
                CMD_COUNT: reply_val = frame_info.len[7:0];
                default:   reply_val = REPLY_UNKNOWN;
            endcase
        end else if (state == E_WALK && data_last) begin
            reply_ready = 1'b1;
            reply_val   = next_acc;
        end
    end

    // =====================================================================
    // Address walk and reply handoff
    // =====================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= E_IDLE;
            payload_addr <= '0;
            addr_vld     <= 1'b0;
            data_vld     <= 1'b0;
            data_last    <= 1'b0;
            tx_start     <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            // Read data trails the address by one cycle
            data_vld  <= addr_vld;
            data_last <= addr_vld && (payload_addr == last_addr);
            if (addr_vld) begin
                if (payload_addr == last_addr) begin
                    addr_vld <= 1'b0;
                end else begin
                    payload_addr <= payload_addr + 1'b1;
                end
            end
            if (start_walk) begin
                state        <= E_WALK;
                payload_addr <= '0;
                addr_vld     <= 1'b1;
            end else if (reply_ready || state == E_HOLD) begin
                if (!tx_busy) begin
                    tx_start <= 1'b1;
                    state    <= E_IDLE;
                end else begin
                    state <= E_HOLD;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == E_IDLE && parse_done) begin
            info <= frame_info;
        end
        if (start_walk) begin
            acc <= 8'h00;
        end else if (data_vld) begin
            acc <= next_acc;
        end
        if (reply_ready) begin
            tx_data <= reply_val;
        end
    end

endmodule

`default_nettype wire

/* hdl/uart_tx.sv */
// =========================================================================
// UART transmitter, 8N1
// Sends start bit, eight data bits LSB first and stop bit, busy meanwhile
// =========================================================================
`timescale 1ns/10ps
`default_nettype none

module uart_tx #(
    parameter int CLKS_PER_BIT = 8
) (
    input  wire        clk,
    input  wire        rst_n,
    input  wire  [7:0] tx_data,
    input  wire        tx_start,
    output logic       tx,
    output logic       tx_busy
);

    localparam int CW = $clog2(CLKS_PER_BIT + 1);

    // Stop, data, start; bit 0 is on the line
    logic [9:0]    shift;
    logic [CW-1:0] clk_cnt;
    logic [3:0]    bit_cnt;

    assign tx = shift[0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shift   <= '1;
            clk_cnt <= '0;
            bit_cnt <= '0;
            tx_busy <= 1'b0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                shift   <= {1'b1, tx_data, 1'b0};
                clk_cnt <= '0;
                bit_cnt <= '0;
                tx_busy <= 1'b1;
            end
        end else if (clk_cnt == CW'(CLKS_PER_BIT - 1)) begin
            clk_cnt <= '0;
            // Ones fill in behind so the line idles high
            shift   <= {1'b1, shift[9:1]};
            if (bit_cnt == 4'd9) begin
                tx_busy <= 1'b0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hdl/uart_cmd_top.sv */
// =========================================================================
// UART command endpoint
// Receiver, frame parser, command executor and transmitter in one path
// =========================================================================
`timescale 1ns/10ps
`default_nettype none

module uart_cmd_top #(
    parameter int CLKS_PER_BIT    = 8,
    parameter int MAX_PAYLOAD_LEN = 16
) (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  rx,
    output logic tx
);

    import uart_cmd_pkg::*;

    logic [7:0]                         rx_data;
    logic                               rx_valid;
    frame_info_t                        frame_info;
    logic                               parse_done;
    logic                               parse_error;
    logic [$clog2(MAX_PAYLOAD_LEN)-1:0] payload_addr;
    logic [7:0]                         payload_data;
    logic [7:0]                         tx_data;
    logic                               tx_start;
    logic                               tx_busy;

    uart_rx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_uart_rx (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx       (rx),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    frame_parser #(
        .MAX_PAYLOAD_LEN(MAX_PAYLOAD_LEN)
    ) u_frame_parser (
        .clk          (clk),
        .rst_n        (rst_n),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .payload_addr (payload_addr),
        .payload_data (payload_data),
        .frame_info   (frame_info),
        .parse_done   (parse_done),
        .parse_error  (parse_error)
    );

    cmd_executor #(
        .MAX_PAYLOAD_LEN(MAX_PAYLOAD_LEN)
    ) u_cmd_executor (
        .clk          (clk),
        .rst_n        (rst_n),
        .frame_info   (frame_info),
        .parse_done   (parse_done),
        .parse_error  (parse_error),
        .payload_data (payload_data),
        .tx_busy      (tx_busy),
        .payload_addr (payload_addr),
        .tx_data      (tx_data),
        .tx_start     (tx_start)
    );

    uart_tx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_uart_tx (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

endmodule

`default_nettype wire

/* verif/uart_cmd_asserts.sv */
// ==========================================================================
// Frame parser assertions
// Done and error pulses and the legal range of the parser FSM
// ==========================================================================
`timescale 1ns/10ps
`default_nettype none

module uart_cmd_asserts (
    input wire       clk,
    input wire       rst_n,
    input wire       parse_done,
    input wire       parse_error,
    input wire [2:0] state
);

    // Encoding of the CHECKSUM state, the highest one in use
    localparam logic [2:0] LAST_STATE = 3'd6;

    done_error_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(parse_done && parse_error)
    ) else $error("parse_done and parse_error were high in the same cycle");

    done_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) parse_done |=> !parse_done
    ) else $error("parse_done stayed high for more than one cycle");

    error_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) parse_error |=> !parse_error
    ) else $error("parse_error stayed high for more than one cycle");

    state_legal: assert property (
        @(posedge clk) disable iff (!rst_n) state <= LAST_STATE
    ) else $error("Frame parser state left its legal set");

endmodule

bind frame_parser uart_cmd_asserts u_asserts (
    .clk         (clk),
    .rst_n       (rst_n),
    .parse_done  (parse_done),
    .parse_error (parse_error),
    .state       (state)
);

`default_nettype wire

/* verif/uart_cmd_checker.sv */
// ==========================================================================
// Reply checker
// Decodes 8N1 bytes on the DUT tx line and compares them in order with
// the queue of expected replies
// ==========================================================================
`timescale 1ns/10ps
`default_nettype none

module uart_cmd_checker #(
    parameter int CLKS_PER_BIT = 8
) (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        tx,
    input  wire  [7:0] exp_data,
    input  wire        exp_push,
    input  wire        end_check,
    output int         reply_count,
    output int         mismatch_count,
    output int         missing_count,
    output int         extra_count,
    output int         framing_count
);

    logic [7:0] exp_q [$];
    logic [7:0] shift;
    bit         busy;
    bit         end_seen;
    int         cnt;
    int         bit_idx;

    task automatic compare_reply(input logic [7:0] got);
        logic [7:0] want;
        reply_count++;
        if (exp_q.size() == 0) begin
            extra_count++;
            $display("Unexpected reply 0x%02h at %0t while no reply was pending", got, $time);
        end else begin
            want = exp_q.pop_front();
            if (got !== want) begin
                mismatch_count++;
                $display("Mismatch at %0t: expected 0x%02h, received 0x%02h",
                         $time, want, got);
            end
        end
    endtask

    // Edges counted from the start bit, each bit sampled at its middle
    always @(posedge clk) begin
        if (exp_push) begin
            exp_q.push_back(exp_data);
        end
        if (!rst_n) begin
            busy = 1'b0;
        end else if (!busy) begin
            if (tx == 1'b0) begin
                busy = 1'b1;
                cnt  = 1;
            end
        end else begin
            cnt = cnt + 1;
            if (cnt % CLKS_PER_BIT == CLKS_PER_BIT / 2) begin
                bit_idx = cnt / CLKS_PER_BIT;
                if (bit_idx == 0 && tx !== 1'b0) begin
                    busy = 1'b0;
                    framing_count++;
                    $display("Reply start bit at %0t did not stay low", $time);
                end else if (bit_idx >= 1 && bit_idx <= 8) begin
                    shift[bit_idx - 1] = tx;
                end else if (bit_idx == 9) begin
                    busy = 1'b0;
                    if (tx !== 1'b1) begin
                        framing_count++;
                        $display("Reply at %0t ended without a high stop bit", $time);
                    end else begin
                        compare_reply(shift);
                    end
                end
            end
        end
        if (end_check && !end_seen) begin
            end_seen      = 1'b1;
            missing_count = exp_q.size();
            if (missing_count != 0) begin
                $display("%0d expected replies never arrived", missing_count);
            end
        end
    end

endmodule

`default_nettype wire

/* verif/tb_uart_cmd.sv */
// ==========================================================================
// UART command endpoint testbench
// Sends framed commands on rx, predicts each reply and lets the checker
// compare it with what the DUT sends back on tx
// ==========================================================================
`timescale 1ns/10ps
`default_nettype none

module tb_uart_cmd;

    import uart_cmd_pkg::*;

    localparam int     CLKS_PER_BIT    = 8;
    localparam int     MAX_PAYLOAD_LEN = 16;
    localparam int     CLK_PERIOD_NS   = 40;
    // Frames and stray bytes sent over the whole run
    localparam int     NUM_FRAMES      = 35;
    localparam int     NOISE_BYTES     = 7;
    localparam longint BYTE_NS         = 10 * CLKS_PER_BIT * CLK_PERIOD_NS;
    localparam longint WATCHDOG_NS     = 2 * BYTE_NS *
        (NUM_FRAMES * (MAX_PAYLOAD_LEN + 6) + NOISE_BYTES + NUM_FRAMES);

    typedef logic [7:0] payload_t [MAX_PAYLOAD_LEN];

    logic       clk;
    logic       rst_n;
    logic       rx;
    logic       tx;
    logic [7:0] exp_data;
    logic       exp_push;
    logic       end_check;
    int         reply_count;
    int         mismatch_count;
    int         missing_count;
    int         extra_count;
    int         framing_count;
    int         expected_total;
    payload_t   pay;

    uart_cmd_top #(
        .CLKS_PER_BIT    (CLKS_PER_BIT),
        .MAX_PAYLOAD_LEN (MAX_PAYLOAD_LEN)
    ) dut (
        .clk   (clk),
        .rst_n (rst_n),
        .rx    (rx),
        .tx    (tx)
    );

    uart_cmd_checker #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_checker (
        .clk            (clk),
        .rst_n          (rst_n),
        .tx             (tx),
        .exp_data       (exp_data),
        .exp_push       (exp_push),
        .end_check      (end_check),
        .reply_count    (reply_count),
        .mismatch_count (mismatch_count),
        .missing_count  (missing_count),
        .extra_count    (extra_count),
        .framing_count  (framing_count)
    );

    always #(CLK_PERIOD_NS / 2) clk = ~clk;

    // Expected reply from the command rules
    function automatic logic [7:0] expected_reply(
        input logic [7:0] cmd,
        input int         len,
        input payload_t   data,
        input bit         corrupt
    );
        logic [7:0] acc;
        acc = 8'h00;
        if (corrupt || len > MAX_PAYLOAD_LEN) begin
            return REPLY_FRAME_ERR;
        end
        case (cmd)
            CMD_SUM: begin
                for (int i = 0; i < len; i++) begin
                    acc = acc + data[i];
                end
            end
            CMD_XOR: begin
                for (int i = 0; i < len; i++) begin
                    acc = acc ^ data[i];
                end
            end
            CMD_COUNT: acc = 8'(len);
            default:   acc = REPLY_UNKNOWN;
        endcase
        return acc;
    endfunction

    // Holds one bit on rx for a full bit time
    task automatic drive_bit(input logic value);
        @(posedge clk);
        #2 rx = value;
        repeat (CLKS_PER_BIT - 1) @(posedge clk);
    endtask

    task automatic send_byte(input logic [7:0] value);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(value[i]);
        end
        drive_bit(1'b1);
    endtask

    task automatic push_expected(input logic [7:0] value);
        @(posedge clk);
        #2;
        exp_data = value;
        exp_push = 1'b1;
        @(posedge clk);
        #2 exp_push = 1'b0;
        expected_total++;
    endtask

    task automatic fill_payload(input int len);
        for (int i = 0; i < MAX_PAYLOAD_LEN; i++) begin
            pay[i] = (i < len) ? 8'($urandom) : 8'h00;
        end
    endtask

    // Stray bytes with no SOF1 among them
    task automatic send_noise(input int count);
        logic [7:0] value;
        for (int i = 0; i < count; i++) begin
            value = 8'($urandom);
            if (value == SOF1_BYTE) begin
                value = 8'h00;
            end
            send_byte(value);
        end
    endtask

    // Header only when the length is over the limit
    task automatic send_frame(input logic [7:0] cmd, input int len, input bit corrupt);
        logic [15:0] len16;
        logic [7:0]  sum;
        len16 = 16'(len);
        sum   = cmd + len16[15:8] + len16[7:0];
        push_expected(expected_reply(cmd, len, pay, corrupt));
        send_byte(SOF1_BYTE);
        send_byte(SOF2_BYTE);
        send_byte(cmd);
        send_byte(len16[15:8]);
        send_byte(len16[7:0]);
        if (len <= MAX_PAYLOAD_LEN) begin
            for (int i = 0; i < len; i++) begin
                send_byte(pay[i]);
                sum = sum + pay[i];
            end
            send_byte(corrupt ? ~sum : sum);
        end
        wait (reply_count >= expected_total);
        repeat (4) @(posedge clk);
    endtask

    task automatic send_random_frame(input logic [7:0] cmd, input bit corrupt);
        int len;
        len = $urandom_range(MAX_PAYLOAD_LEN, 1);
        fill_payload(len);
        send_frame(cmd, len, corrupt);
    endtask

    // ======================================================================
    // Watchdog
    // ======================================================================
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: run stopped after %0d ns with %0d of %0d replies received",
                 WATCHDOG_NS, reply_count, expected_total);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // ======================================================================
    // Stimulus
    // ======================================================================
    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        rx             = 1'b1;
        exp_data       = 8'h00;
        exp_push       = 1'b0;
        end_check      = 1'b0;
        expected_total = 0;
        void'($urandom(73));
        repeat (5) @(posedge clk);
        #2 rst_n = 1'b1;
        repeat (10) @(posedge clk);

        repeat (6) send_random_frame(CMD_SUM, 1'b0);
        repeat (6) send_random_frame(CMD_XOR, 1'b0);
        for (int len = 0; len <= MAX_PAYLOAD_LEN; len++) begin
            fill_payload(len);
            send_frame(CMD_COUNT, len, 1'b0);
        end
        send_random_frame(8'h00, 1'b0);
        send_random_frame(8'h5A, 1'b0);
        send_random_frame(CMD_SUM, 1'b1);
        send_random_frame(CMD_XOR, 1'b1);
        send_frame(CMD_SUM, MAX_PAYLOAD_LEN + 1, 1'b0);

        // Noise and a broken SOF pair ahead of a good frame
        send_noise(NOISE_BYTES - 2);
        send_byte(SOF1_BYTE);
        send_byte(8'h3C);
        send_random_frame(CMD_SUM, 1'b0);

        // Quiet line for two byte times so a late extra reply is still seen
        repeat (2 * 10 * CLKS_PER_BIT) @(posedge clk);
        @(posedge clk);
        #2 end_check = 1'b1;
        repeat (3) @(posedge clk);
        $display("Errors: mismatch %0d, missing %0d, extra %0d, framing %0d",
                 mismatch_count, missing_count, extra_count, framing_count);
        if (mismatch_count + missing_count + extra_count + framing_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* uart_cmd.f */
hdl/uart_cmd_pkg.sv
hdl/uart_rx.sv
hdl/frame_parser.sv
hdl/cmd_executor.sv
hdl/uart_tx.sv
hdl/uart_cmd_top.sv
verif/uart_cmd_asserts.sv
verif/uart_cmd_checker.sv
verif/tb_uart_cmd.sv

/* Makefile */
TOOL      = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_uart_cmd
FILELIST  = uart_cmd.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
